/* hw/fb_defs.svh */
// ================================================
// Framebuffer clear constants: stream widths,
// command opcodes and register indices
// ================================================
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// Stream and pixel widths
`define FB_CMD_WIDTH            16
`define FB_POS_WIDTH            11
`define FB_PIXELS_PER_BEAT      2
`define FB_BEAT_WIDTH           32
`define FB_SUB_PIXEL_WIDTH      6

// Opcodes in header bits 15:12
`define FB_OP_REG               4'd0
`define FB_OP_CLEAR             4'd1
`define FB_OP_COMMIT            4'd2

// Register indices in header bits 3:0
`define FB_REG_X_RES            4'd0
`define FB_REG_Y_RES            4'd1
`define FB_REG_SCISSOR_EN       4'd2
`define FB_REG_SCISSOR_START_X  4'd3
`define FB_REG_SCISSOR_START_Y  4'd4
`define FB_REG_SCISSOR_END_X    4'd5
`define FB_REG_SCISSOR_END_Y    4'd6
`define FB_REG_CLEAR_RG         4'd7
`define FB_REG_CLEAR_B          4'd8
`define FB_REG_CLEAR_DEPTH      4'd9

`endif

/* hw/fb_pkg.sv */
// ================================================
// Framebuffer types: screen coordinate, RGB565
// pixel, depth value and command opcode
// ================================================
`include "fb_defs.svh"

package fb_pkg;

    // Unsigned screen coordinate
    typedef logic [`FB_POS_WIDTH-1:0] screen_pos_t;

    // Stream colour format, red in the upper bits
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef logic [15:0] depth_t;

    // Command opcodes
    typedef enum logic [3:0] {
        OP_REG    = `FB_OP_REG,
        OP_CLEAR  = `FB_OP_CLEAR,
        OP_COMMIT = `FB_OP_COMMIT
    } fb_op_t;

endpackage

/* hw/fb_cmd_decode.sv */
// ================================================
// Command decoder: register file, clear start and
// commit/swap handshake
// ================================================
`timescale 1ns/100ps
`include "fb_defs.svh"

module fb_cmd_decode (
    input  logic                      aclk,
    input  logic                      rst_n,

    input  logic                      cmd_tvalid,
    output logic                      cmd_tready,
    input  logic [`FB_CMD_WIDTH-1:0]  cmd_tdata,

    input  logic                      color_busy,
    input  logic                      depth_busy,
    input  logic                      fb_swapped,

    output logic                      color_start,
    output logic                      depth_start,
    output logic                      swap_fb,

    output fb_pkg::screen_pos_t       x_res,
    output fb_pkg::screen_pos_t       y_res,
    output fb_pkg::screen_pos_t       scissor_start_x,
    output fb_pkg::screen_pos_t       scissor_start_y,
    output fb_pkg::screen_pos_t       scissor_end_x,
    output fb_pkg::screen_pos_t       scissor_end_y,
    output logic                      scissor_en,

    output fb_pkg::rgb565_t           clear_color,
    output fb_pkg::depth_t            clear_depth
);
    import fb_pkg::*;

    localparam int SPW = `FB_SUB_PIXEL_WIDTH;

    typedef enum logic [1:0] {
        ST_HEADER,
        ST_PAYLOAD,
        ST_WAIT_SWAP
    } state_t;

    state_t             state;
    state_t             state_nxt;
    fb_op_t             op;
    logic [3:0]         reg_idx;
    logic               cmd_fire;
    logic               header_fire;
    logic               clear_fire;
    logic               ready_nxt;
    logic [SPW-1:0]     clear_r;
    logic [SPW-1:0]     clear_g;
    logic [SPW-1:0]     clear_b;

    assign op          = fb_op_t'(cmd_tdata[15:12]);
    assign cmd_fire    = cmd_tvalid && cmd_tready;
    assign header_fire = cmd_fire && (state == ST_HEADER);
    assign clear_fire  = header_fire && (op == OP_CLEAR);

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_HEADER:
            begin
                if (header_fire && (op == OP_REG))
                    state_nxt = ST_PAYLOAD;
                else if (header_fire && (op == OP_COMMIT))
                    state_nxt = ST_WAIT_SWAP;
            end
            ST_PAYLOAD:
            begin
                if (cmd_fire)
                    state_nxt = ST_HEADER;
            end
            ST_WAIT_SWAP:
            begin
                // The display side acknowledges after the pulse has gone
                if (fb_swapped && !swap_fb)
                    state_nxt = ST_HEADER;
            end
            default:
                state_nxt = ST_HEADER;
        endcase
    end

    // Stall the command stream while a clear is starting or running
    assign ready_nxt = (state_nxt != ST_WAIT_SWAP) && !clear_fire
                       && !color_start && !depth_start
                       && !color_busy && !depth_busy;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state       <= ST_HEADER;
            cmd_tready  <= 1'b0;
            color_start <= 1'b0;
            depth_start <= 1'b0;
            swap_fb     <= 1'b0;
            reg_idx     <= '0;
        end
        else
        begin
            state       <= state_nxt;
            cmd_tready  <= ready_nxt;
            color_start <= clear_fire && cmd_tdata[0];
            depth_start <= clear_fire && cmd_tdata[1];
            swap_fb     <= header_fire && (op == OP_COMMIT);
            if (header_fire)
                reg_idx <= cmd_tdata[3:0];
        end
    end

    // Register file
    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            x_res           <= '0;
            y_res           <= '0;
            scissor_en      <= 1'b0;
            scissor_start_x <= '0;
            scissor_start_y <= '0;
            scissor_end_x   <= '0;
            scissor_end_y   <= '0;
            clear_r         <= '0;
            clear_g         <= '0;
            clear_b         <= '0;
            clear_depth     <= '0;
        end
        else if (cmd_fire && (state == ST_PAYLOAD))
        begin
            case (reg_idx)
                `FB_REG_X_RES:           x_res           <= cmd_tdata[`FB_POS_WIDTH-1:0];
                `FB_REG_Y_RES:           y_res           <= cmd_tdata[`FB_POS_WIDTH-1:0];
                `FB_REG_SCISSOR_EN:      scissor_en      <= cmd_tdata[0];
                `FB_REG_SCISSOR_START_X: scissor_start_x <= cmd_tdata[`FB_POS_WIDTH-1:0];
                `FB_REG_SCISSOR_START_Y: scissor_start_y <= cmd_tdata[`FB_POS_WIDTH-1:0];
                `FB_REG_SCISSOR_END_X:   scissor_end_x   <= cmd_tdata[`FB_POS_WIDTH-1:0];
                `FB_REG_SCISSOR_END_Y:   scissor_end_y   <= cmd_tdata[`FB_POS_WIDTH-1:0];
                `FB_REG_CLEAR_RG:
                begin
                    clear_r <= cmd_tdata[2*SPW-1:SPW];
                    clear_g <= cmd_tdata[SPW-1:0];
                end
                `FB_REG_CLEAR_B:         clear_b         <= cmd_tdata[SPW-1:0];
                `FB_REG_CLEAR_DEPTH:     clear_depth     <= cmd_tdata;
                default:
                begin
                end
            endcase
        end
    end

    // 6 bit internal colour to RGB565, dropping the red and blue LSB
    assign clear_color.r = clear_r[SPW-1 -: 5];
    assign clear_color.g = clear_g;
    assign clear_color.b = clear_b[SPW-1 -: 5];

    a_swap_single_pulse: assert property (
        @(posedge aclk) disable iff (!rst_n)
        swap_fb |=> !swap_fb
    );

endmodule

/* hw/fb_clear_walker.sv */
// ================================================
// Frame walker: one clear pixel per accepted
// cycle with its scissor strobe
// ================================================
`timescale 1ns/100ps
`include "fb_defs.svh"

module fb_clear_walker #(
    parameter type pixel_t = logic [`FB_BEAT_WIDTH/`FB_PIXELS_PER_BEAT-1:0]
) (
    input  logic                 aclk,
    input  logic                 rst_n,

    input  logic                 start,
    output logic                 busy,

    input  fb_pkg::screen_pos_t  x_res,
    input  fb_pkg::screen_pos_t  y_res,
    input  fb_pkg::screen_pos_t  scissor_start_x,
    input  fb_pkg::screen_pos_t  scissor_start_y,
    input  fb_pkg::screen_pos_t  scissor_end_x,
    input  fb_pkg::screen_pos_t  scissor_end_y,
    input  logic                 scissor_en,
    input  pixel_t               clear_value,

    output logic                 px_valid,
    input  logic                 px_ready,
    output pixel_t               px_data,
    output logic                 px_strb,
    output logic                 px_last
);
    import fb_pkg::*;

    screen_pos_t  x;
    screen_pos_t  y;
    screen_pos_t  x_end;
    screen_pos_t  y_end;
    logic         in_x;
    logic         in_y;
    logic         px_fire;

    assign x_end   = x_res - screen_pos_t'(1);
    assign y_end   = y_res - screen_pos_t'(1);
    assign px_fire = px_valid && px_ready;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy <= 1'b0;
            x    <= '0;
            y    <= '0;
        end
        else if (start)
        begin
            busy <= 1'b1;
            x    <= '0;
            y    <= '0;
        end
        else if (px_fire)
        begin
            if (px_last)
                busy <= 1'b0;
            // Row major, wrap x at the end of each line
            if (x == x_end)
            begin
                x <= '0;
                y <= y + screen_pos_t'(1);
            end
            else
            begin
                x <= x + screen_pos_t'(1);
            end
        end
    end

    // Scissor rectangle is inclusive at start, exclusive at end
    assign in_x = (x >= scissor_start_x) && (x < scissor_end_x);
    assign in_y = (y >= scissor_start_y) && (y < scissor_end_y);

    assign px_valid = busy;
    assign px_data  = clear_value;
    assign px_strb  = !scissor_en || (in_x && in_y);
    assign px_last  = (x == x_end) && (y == y_end);

    a_no_start_while_busy: assert property (
        @(posedge aclk) disable iff (!rst_n)
        start |-> !busy
    );

endmodule

/* hw/fb_beat_packer.sv */
// ================================================
// Beat packer: pixel pairs into 32 bit stream
// beats with per pixel strobes and tlast
// ================================================
`timescale 1ns/100ps
`include "fb_defs.svh"

module fb_beat_packer #(
    parameter type pixel_t = logic [`FB_BEAT_WIDTH/`FB_PIXELS_PER_BEAT-1:0]
) (
    input  logic                              aclk,
    input  logic                              rst_n,

    input  logic                              px_valid,
    output logic                              px_ready,
    input  pixel_t                            px_data,
    input  logic                              px_strb,
    input  logic                              px_last,

    output logic                              tvalid,
    input  logic                              tready,
    output logic [`FB_BEAT_WIDTH-1:0]         tdata,
    output logic [`FB_PIXELS_PER_BEAT-1:0]    tstrb,
    output logic                              tlast
);

    logic    half_valid;
    pixel_t  half_data;
    logic    half_strb;
    logic    px_fire;
    logic    beat_load;

    // Second pixel of a pair needs room in the output register
    assign px_ready  = !half_valid || !tvalid || tready;
    assign px_fire   = px_valid && px_ready;
    assign beat_load = px_fire && half_valid;

    always_ff @(posedge aclk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            half_valid <= 1'b0;
            tvalid     <= 1'b0;
        end
        else
        begin
            if (px_fire)
                half_valid <= !half_valid;
            if (beat_load)
                tvalid <= 1'b1;
            else if (tready)
                tvalid <= 1'b0;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (px_fire && !half_valid)
        begin
            half_data <= px_data;
            half_strb <= px_strb;
        end
        // First pixel of the pair lands in the low half
        if (beat_load)
        begin
            tdata <= {px_data, half_data};
            tstrb <= {px_strb, half_strb};
            tlast <= px_last;
        end
    end

    a_beat_stable: assert property (
        @(posedge aclk) disable iff (!rst_n)
        tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tstrb) && $stable(tlast)
    );

    a_last_on_second_pixel: assert property (
        @(posedge aclk) disable iff (!rst_n)
        px_fire && !half_valid |-> !px_last
    );

endmodule

/* hw/fb_clear_top.sv */
// ================================================
// Framebuffer clear top: decoder, colour and
// depth walkers and beat packers
// ================================================
`timescale 1ns/100ps
`include "fb_defs.svh"

module fb_clear_top (
    input  logic                              aclk,
    input  logic                              rst_n,

    input  logic                              cmd_tvalid,
    output logic                              cmd_tready,
    input  logic [`FB_CMD_WIDTH-1:0]          cmd_tdata,

    output logic                              color_tvalid,
    input  logic                              color_tready,
    output logic [`FB_BEAT_WIDTH-1:0]         color_tdata,
    output logic [`FB_PIXELS_PER_BEAT-1:0]    color_tstrb,
    output logic                              color_tlast,

    output logic                              depth_tvalid,
    input  logic                              depth_tready,
    output logic [`FB_BEAT_WIDTH-1:0]         depth_tdata,
    output logic [`FB_PIXELS_PER_BEAT-1:0]    depth_tstrb,
    output logic                              depth_tlast,

    output logic                              swap_fb,
    input  logic                              fb_swapped
);
    import fb_pkg::*;

    screen_pos_t  x_res;
    screen_pos_t  y_res;
    screen_pos_t  scissor_start_x;
    screen_pos_t  scissor_start_y;
    screen_pos_t  scissor_end_x;
    screen_pos_t  scissor_end_y;
    logic         scissor_en;
    rgb565_t      clear_color;
    depth_t       clear_depth;

    logic         color_start;
    logic         color_busy;
    logic         depth_start;
    logic         depth_busy;

    // Walker to packer pixel streams
    logic         color_px_valid;
    logic         color_px_ready;
    rgb565_t      color_px_data;
    logic         color_px_strb;
    logic         color_px_last;
    logic         depth_px_valid;
    logic         depth_px_ready;
    depth_t       depth_px_data;
    logic         depth_px_strb;
    logic         depth_px_last;

    fb_cmd_decode cmd_decode_i (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .cmd_tvalid      (cmd_tvalid),
        .cmd_tready      (cmd_tready),
        .cmd_tdata       (cmd_tdata),
        .color_busy      (color_busy),
        .depth_busy      (depth_busy),
        .fb_swapped      (fb_swapped),
        .color_start     (color_start),
        .depth_start     (depth_start),
        .swap_fb         (swap_fb),
        .x_res           (x_res),
        .y_res           (y_res),
        .scissor_start_x (scissor_start_x),
        .scissor_start_y (scissor_start_y),
        .scissor_end_x   (scissor_end_x),
        .scissor_end_y   (scissor_end_y),
        .scissor_en      (scissor_en),
        .clear_color     (clear_color),
        .clear_depth     (clear_depth)
    );

    fb_clear_walker #(
        .pixel_t (rgb565_t)
    ) color_walker_i (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .start           (color_start),
        .busy            (color_busy),
        .x_res           (x_res),
        .y_res           (y_res),
        .scissor_start_x (scissor_start_x),
        .scissor_start_y (scissor_start_y),
        .scissor_end_x   (scissor_end_x),
        .scissor_end_y   (scissor_end_y),
        .scissor_en      (scissor_en),
        .clear_value     (clear_color),
        .px_valid        (color_px_valid),
        .px_ready        (color_px_ready),
        .px_data         (color_px_data),
        .px_strb         (color_px_strb),
        .px_last         (color_px_last)
    );

    fb_clear_walker #(
        .pixel_t (depth_t)
    ) depth_walker_i (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .start           (depth_start),
        .busy            (depth_busy),
        .x_res           (x_res),
        .y_res           (y_res),
        .scissor_start_x (scissor_start_x),
        .scissor_start_y (scissor_start_y),
        .scissor_end_x   (scissor_end_x),
        .scissor_end_y   (scissor_end_y),
        .scissor_en      (scissor_en),
        .clear_value     (clear_depth),
        .px_valid        (depth_px_valid),
        .px_ready        (depth_px_ready),
        .px_data         (depth_px_data),
        .px_strb         (depth_px_strb),
        .px_last         (depth_px_last)
    );

    fb_beat_packer #(
        .pixel_t (rgb565_t)
    ) color_packer_i (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .px_valid (color_px_valid),
        .px_ready (color_px_ready),
        .px_data  (color_px_data),
        .px_strb  (color_px_strb),
        .px_last  (color_px_last),
        .tvalid   (color_tvalid),
        .tready   (color_tready),
        .tdata    (color_tdata),
        .tstrb    (color_tstrb),
        .tlast    (color_tlast)
    );

    fb_beat_packer #(
        .pixel_t (depth_t)
    ) depth_packer_i (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .px_valid (depth_px_valid),
        .px_ready (depth_px_ready),
        .px_data  (depth_px_data),
        .px_strb  (depth_px_strb),
        .px_last  (depth_px_last),
        .tvalid   (depth_tvalid),
        .tready   (depth_tready),
        .tdata    (depth_tdata),
        .tstrb    (depth_tstrb),
        .tlast    (depth_tlast)
    );

endmodule

/* dv/fb_clear_tb.sv */
// ==================================================
// Framebuffer clear testbench: pattern file commands,
// random back-pressure, beat and swap checks
// ==================================================
`timescale 1ns/100ps
`include "fb_defs.svh"

module fb_clear_tb;

    localparam int CMD_TIMEOUT   = 400;
    localparam int DRAIN_TIMEOUT = 2000;

    logic                            aclk;
    logic                            rst_n;
    logic                            cmd_tvalid;
    logic                            cmd_tready;
    logic [`FB_CMD_WIDTH-1:0]        cmd_tdata;
    logic                            color_tvalid;
    logic                            color_tready;
    logic [`FB_BEAT_WIDTH-1:0]       color_tdata;
    logic [`FB_PIXELS_PER_BEAT-1:0]  color_tstrb;
    logic                            color_tlast;
    logic                            depth_tvalid;
    logic                            depth_tready;
    logic [`FB_BEAT_WIDTH-1:0]       depth_tdata;
    logic [`FB_PIXELS_PER_BEAT-1:0]  depth_tstrb;
    logic                            depth_tlast;
    logic                            swap_fb;
    logic                            fb_swapped;

    // Expected beats as {last, strb, data}
    logic [34:0]               color_q[$];
    logic [34:0]               depth_q[$];
    logic [34:0]               color_exp;
    logic [34:0]               depth_exp;
    logic [`FB_CMD_WIDTH-1:0]  cmd_q[$];

    integer           seed;
    integer           error_count;
    integer           tests_run;
    integer           tests_passed;
    integer           test_errs_start;
    integer           swaps_expected;
    integer           swaps_seen;
    integer           color_started;
    integer           color_done;
    integer           depth_started;
    integer           depth_done;
    logic             swap_wait;
    logic             swap_prev;
    logic             expect_payload;
    logic             timed_out;
    logic [8*32-1:0]  test_name;

    fb_clear_top dut_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .cmd_tvalid   (cmd_tvalid),
        .cmd_tready   (cmd_tready),
        .cmd_tdata    (cmd_tdata),
        .color_tvalid (color_tvalid),
        .color_tready (color_tready),
        .color_tdata  (color_tdata),
        .color_tstrb  (color_tstrb),
        .color_tlast  (color_tlast),
        .depth_tvalid (depth_tvalid),
        .depth_tready (depth_tready),
        .depth_tdata  (depth_tdata),
        .depth_tstrb  (depth_tstrb),
        .depth_tlast  (depth_tlast),
        .swap_fb      (swap_fb),
        .fb_swapped   (fb_swapped)
    );

    always #2 aclk = ~aclk;

    task check_equal(input string name, input logic [31:0] expected, input logic [31:0] actual);
        begin
            if (actual !== expected)
            begin
                $display("Fail at %0t ns: %0s expected %h, got %h",
                         $time, name, expected, actual);
                error_count = error_count + 1;
            end
        end
    endtask

    // Follows the command format to know which words start a clear or a commit
    task track_command(input logic [`FB_CMD_WIDTH-1:0] word);
        begin
            if (color_started != color_done && color_q.size() > 0 && !color_q[0][34])
            begin
                $display("Command %h accepted at %0t ns during a colour clear", word, $time);
                error_count = error_count + 1;
            end
            if (depth_started != depth_done && depth_q.size() > 0 && !depth_q[0][34])
            begin
                $display("Command %h accepted at %0t ns during a depth clear", word, $time);
                error_count = error_count + 1;
            end
            if (swap_wait)
            begin
                $display("Command %h accepted at %0t ns before fb_swapped", word, $time);
                error_count = error_count + 1;
            end
            if (expect_payload)
                expect_payload = 1'b0;
            else if (word[15:12] == `FB_OP_REG)
                expect_payload = 1'b1;
            else if (word[15:12] == `FB_OP_CLEAR)
            begin
                if (word[0])
                    color_started = color_started + 1;
                if (word[1])
                    depth_started = depth_started + 1;
            end
            else if (word[15:12] == `FB_OP_COMMIT)
                swap_wait = 1'b1;
        end
    endtask

    always @(posedge aclk)
    begin
        if (rst_n)
        begin
            if (cmd_tvalid && cmd_tready)
                track_command(cmd_tdata);
            if (color_tvalid && color_tready)
            begin
                if (color_q.size() == 0)
                begin
                    $display("Unexpected colour beat at %0t ns", $time);
                    error_count = error_count + 1;
                end
                else
                begin
                    color_exp = color_q.pop_front();
                    check_equal("color_tdata", color_exp[31:0], color_tdata);
                    check_equal("color_tstrb", color_exp[33:32], color_tstrb);
                    check_equal("color_tlast", color_exp[34], color_tlast);
                end
                if (color_tlast)
                    color_done = color_done + 1;
            end
            if (depth_tvalid && depth_tready)
            begin
                if (depth_q.size() == 0)
                begin
                    $display("Unexpected depth beat at %0t ns", $time);
                    error_count = error_count + 1;
                end
                else
                begin
                    depth_exp = depth_q.pop_front();
                    check_equal("depth_tdata", depth_exp[31:0], depth_tdata);
                    check_equal("depth_tstrb", depth_exp[33:32], depth_tstrb);
                    check_equal("depth_tlast", depth_exp[34], depth_tlast);
                end
                if (depth_tlast)
                    depth_done = depth_done + 1;
            end
            if (swap_fb)
            begin
                if (swap_prev)
                begin
                    $display("swap_fb stayed high for two cycles at %0t ns", $time);
                    error_count = error_count + 1;
                end
                swaps_seen = swaps_seen + 1;
            end
            if (fb_swapped)
                swap_wait = 1'b0;
            swap_prev = swap_fb;
        end
    end

    // Ready three cycles out of four on each stream
    always @(posedge aclk)
    begin
        #1;
        color_tready = ($random(seed) & 3) != 0;
        depth_tready = ($random(seed) & 3) != 0;
    end

    // Display side acknowledges a swap a few cycles later
    always @(posedge aclk)
    begin
        if (rst_n && swap_fb)
        begin
            repeat (3) @(posedge aclk);
            #1;
            fb_swapped = 1'b1;
            @(posedge aclk);
            #1;
            fb_swapped = 1'b0;
        end
    end

    task send_cmd(input logic [`FB_CMD_WIDTH-1:0] word);
        integer n;
        logic   accepted;
        begin
            cmd_tvalid = 1'b1;
            cmd_tdata  = word;
            accepted   = 1'b0;
            n = 0;
            while (!accepted && n < CMD_TIMEOUT)
            begin
                @(posedge aclk);
                accepted = cmd_tready;
                n = n + 1;
            end
            #1;
            if (!accepted)
            begin
                $display("Timeout: command %h was not accepted in %0d cycles", word, CMD_TIMEOUT);
                error_count = error_count + 1;
                timed_out   = 1'b1;
            end
        end
    endtask

    task run_test;
        integer i;
        integer n;
        begin
            swaps_seen = 0;
            for (i = 0; i < cmd_q.size() && !timed_out; i = i + 1)
                send_cmd(cmd_q[i]);
            cmd_tvalid = 1'b0;
            n = 0;
            while (!timed_out && n < DRAIN_TIMEOUT && (color_q.size() != 0
                   || depth_q.size() != 0 || swap_wait || swaps_seen < swaps_expected))
            begin
                @(posedge aclk);
                #1;
                n = n + 1;
            end
            if (n >= DRAIN_TIMEOUT)
            begin
                $display("Timeout: expected beats or swaps missing after %0d cycles",
                         DRAIN_TIMEOUT);
                error_count = error_count + 1;
                timed_out   = 1'b1;
            end
            // Quiet window to catch extra beats
            repeat (8) @(posedge aclk);
            #1;
            check_equal("swap_fb pulses", swaps_expected, swaps_seen);
            cmd_q.delete();
            color_q.delete();
            depth_q.delete();
            tests_run = tests_run + 1;
            if (error_count == test_errs_start)
                tests_passed = tests_passed + 1;
            $display("Test %0s: %0s", test_name,
                     (error_count == test_errs_start) ? "pass" : "FAIL");
        end
    endtask

    task run_patterns;
        integer            fd;
        integer            code;
        logic [8*32-1:0]   tok;
        logic [8*128-1:0]  rest;
        logic [31:0]       v_data;
        logic [31:0]       v_strb;
        logic [31:0]       v_last;
        logic              done;
        begin
            fd = $fopen("dv/fb_clear_patterns.txt", "r");
            if (fd == 0)
            begin
                $display("Cannot open the pattern file dv/fb_clear_patterns.txt");
                error_count = error_count + 1;
            end
            else
            begin
                done = 1'b0;
                while (!done && !timed_out)
                begin
                    code = $fscanf(fd, "%s", tok);
                    if (code != 1)
                        done = 1'b1;
                    else if (tok == "#")
                        code = $fgets(rest, fd);
                    else if (tok == "T")
                    begin
                        code = $fscanf(fd, "%s", test_name);
                        test_errs_start = error_count;
                        swaps_expected  = 0;
                    end
                    else if (tok == "C")
                    begin
                        code = $fscanf(fd, "%h", v_data);
                        cmd_q.push_back(v_data[`FB_CMD_WIDTH-1:0]);
                    end
                    else if (tok == "EC" || tok == "ED")
                    begin
                        code = $fscanf(fd, "%h %h %h", v_data, v_strb, v_last);
                        if (tok == "EC")
                            color_q.push_back({v_last[0], v_strb[1:0], v_data});
                        else
                            depth_q.push_back({v_last[0], v_strb[1:0], v_data});
                    end
                    else if (tok == "S")
                        swaps_expected = swaps_expected + 1;
                    else if (tok == "R")
                        run_test;
                    else
                    begin
                        $display("Unknown record %0s in the pattern file", tok);
                        error_count = error_count + 1;
                    end
                end
                $fclose(fd);
            end
        end
    endtask

    initial
    begin
        aclk           = 1'b0;
        rst_n          = 1'b0;
        cmd_tvalid     = 1'b0;
        cmd_tdata      = '0;
        color_tready   = 1'b0;
        depth_tready   = 1'b0;
        fb_swapped     = 1'b0;
        seed           = 75;
        error_count    = 0;
        tests_run      = 0;
        tests_passed   = 0;
        swaps_seen     = 0;
        swaps_expected = 0;
        color_started  = 0;
        color_done     = 0;
        depth_started  = 0;
        depth_done     = 0;
        swap_wait      = 1'b0;
        swap_prev      = 1'b0;
        expect_payload = 1'b0;
        timed_out      = 1'b0;
        test_name      = "none";
        repeat (16) @(posedge aclk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge aclk);
        #1;
        run_patterns;
        if (tests_run == 0)
        begin
            $display("No test was run from the pattern file");
            error_count = error_count + 1;
        end
        $display("Tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 tests_run, tests_passed, tests_run - tests_passed, error_count);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+hw
hw/fb_pkg.sv
hw/fb_cmd_decode.sv
hw/fb_clear_walker.sv
hw/fb_beat_packer.sv
hw/fb_clear_top.sv
dv/fb_clear_tb.sv

/* dv/fb_clear_patterns.txt */
# Records: T name starts a test, C hhhh sends one command word, R runs the test
# EC or ED data strb last is an expected colour or depth beat, S is one expected swap_fb
T color_clear
C 0000 C 0004
C 0001 C 0002
C 0007 C 0AD5
C 0008 C 003C
C 1001
EC AABEAABE 3 0
EC AABEAABE 3 0
EC AABEAABE 3 0
EC AABEAABE 3 1
R
T depth_scissor
C 0001 C 0004
C 0002 C 0001
C 0003 C 0001
C 0004 C 0001
C 0005 C 0003
C 0006 C 0003
C 0009 C BEEF
C 1002
ED BEEFBEEF 0 0
ED BEEFBEEF 0 0
ED BEEFBEEF 2 0
ED BEEFBEEF 1 0
ED BEEFBEEF 2 0
ED BEEFBEEF 1 0
ED BEEFBEEF 0 0
ED BEEFBEEF 0 1
R
T both_clear
C 0000 C 0006
C 0001 C 0002
C 0002 C 0000
C 0009 C 1234
C 1003
EC AABEAABE 3 0
EC AABEAABE 3 0
EC AABEAABE 3 0
EC AABEAABE 3 0
EC AABEAABE 3 0
EC AABEAABE 3 1
ED 12341234 3 0
ED 12341234 3 0
ED 12341234 3 0
ED 12341234 3 0
ED 12341234 3 0
ED 12341234 3 1
R
T commit_swap
C 0000 C 0002
C 0001 C 0001
C 2000
S
C 1001
EC AABEAABE 3 1
R
T held_commands
C 0001 C 0002
C 1001
C 0007 C 0FFF
C 0008 C 0000
C 1001
EC AABEAABE 3 0
EC AABEAABE 3 1
EC FFE0FFE0 3 0
EC FFE0FFE0 3 1
R
